//--- fp2_alu_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fp2 ALU handshake properties
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fp2_alu_props (
  input logic                        i_clk,
  input logic                        i_rst,
  input logic                        i_valid,
  input logic                        i_ready,
  input logic                        o_ready,
  input logic                        o_valid,
  input logic [fp2_pkg::FE_BITS-1:0]  o_re,
  input logic [fp2_pkg::FE_BITS-1:0]  o_im,
  input logic [fp2_pkg::TAG_BITS-1:0] o_tag
);
  import fp2_pkg::*;

  logic pending;

  // Operation in flight from acceptance until its result leaves
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pending <= 1'b0;
    end else if (i_valid && o_ready) begin
      pending <= 1'b1;
    end else if (o_valid && i_ready) begin
      pending <= 1'b0;
    end
  end

  valid_low_in_reset: assert property (@(posedge i_clk) i_rst |=> !o_valid)
    else $error("o_valid high after a reset cycle");

  // Result holds under back-pressure
  result_held: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_re) && $stable(o_im) && $stable(o_tag)))
    else $error("Result changed while stalled");

  result_in_field: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid |-> (o_re < FE_P && o_im < FE_P))
    else $error("Result component not below P");

  // No new operation enters while one is in flight or its result waits
  no_accept_while_busy: assert property (@(posedge i_clk) disable iff (i_rst)
    (pending || o_valid) |-> !o_ready)
    else $error("o_ready high while an operation is outstanding");

endmodule

bind fp2_alu_top fp2_alu_props fp2_alu_props_inst (
  .i_clk (i_clk), .i_rst (i_rst), .i_valid (i_valid), .i_ready (i_ready),
  .o_ready (o_ready), .o_valid (o_valid), .o_re (o_re), .o_im (o_im), .o_tag (o_tag)
);

//--- fp2_alu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fp2 arithmetic unit top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fp2_alu_top (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_valid,
  output logic                        o_ready,
  input  fp2_pkg::fp2_op_e            i_op,
  input  logic                        i_fp_mode,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_a_re,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_a_im,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_b_re,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_b_im,
  input  logic [fp2_pkg::TAG_BITS-1:0] i_tag,
  output logic                        o_valid,
  input  logic                        i_ready,
  output logic [fp2_pkg::FE_BITS-1:0]  o_re,
  output logic [fp2_pkg::FE_BITS-1:0]  o_im,
  output logic [fp2_pkg::TAG_BITS-1:0] o_tag
);
  import fp2_pkg::*;

  // Adder / subtractor link
  logic               as_valid, as_ready, as_sub, as_res_valid, as_res_ready;
  logic [FE_BITS-1:0] as_x, as_y, as_z;
  // Multiplier link
  logic               mul_valid, mul_ready, mul_res_valid, mul_res_ready;
  logic [FE_BITS-1:0] mul_x, mul_y, mul_z;

  fp2_sequencer fp2_sequencer_inst (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_valid (i_valid), .o_ready (o_ready), .i_op (i_op), .i_fp_mode (i_fp_mode),
    .i_a_re (i_a_re), .i_a_im (i_a_im), .i_b_re (i_b_re), .i_b_im (i_b_im),
    .i_tag (i_tag),
    .o_valid (o_valid), .i_ready (i_ready), .o_re (o_re), .o_im (o_im), .o_tag (o_tag),
    .o_as_valid (as_valid), .i_as_ready (as_ready), .o_as_sub (as_sub),
    .o_as_x (as_x), .o_as_y (as_y),
    .i_as_res_valid (as_res_valid), .o_as_res_ready (as_res_ready), .i_as_z (as_z),
    .o_mul_valid (mul_valid), .i_mul_ready (mul_ready),
    .o_mul_x (mul_x), .o_mul_y (mul_y),
    .i_mul_res_valid (mul_res_valid), .o_mul_res_ready (mul_res_ready), .i_mul_z (mul_z)
  );

  fp_add_sub fp_add_sub_inst (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_valid (as_valid), .o_ready (as_ready), .i_sub (as_sub),
    .i_x (as_x), .i_y (as_y),
    .o_valid (as_res_valid), .i_ready (as_res_ready), .o_z (as_z)
  );

  fp_mul_iter fp_mul_iter_inst (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_valid (mul_valid), .o_ready (mul_ready),
    .i_x (mul_x), .i_y (mul_y),
    .o_valid (mul_res_valid), .i_ready (mul_res_ready), .o_z (mul_z)
  );

endmodule

//--- fp2_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fp2 ALU shared definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fp2_pkg;

  // Field element width and prime
  localparam int FE_BITS = 16;
  localparam logic [FE_BITS-1:0] FE_P = 16'd65521;

  // Pass-through tag width
  localparam int TAG_BITS = 8;

  // Step counter must hold the value FE_BITS
  localparam int STEP_BITS = $clog2(FE_BITS + 1);

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } fp2_op_e;

  typedef enum logic [3:0] {
    S_IDLE,
    S_AS_RE,
    S_AS_IM,
    S_MUL0,
    S_MUL1,
    S_MUL2,
    S_MUL3,
    S_COMB_RE,
    S_COMB_IM,
    S_DONE
  } seq_state_e;

endpackage

//--- fp2_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fp2 operation sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fp2_sequencer (
  input  logic                        i_clk,
  input  logic                        i_rst,
  // Operation in
  input  logic                        i_valid,
  output logic                        o_ready,
  input  fp2_pkg::fp2_op_e            i_op,
  input  logic                        i_fp_mode,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_a_re,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_a_im,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_b_re,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_b_im,
  input  logic [fp2_pkg::TAG_BITS-1:0] i_tag,
  // Result out
  output logic                        o_valid,
  input  logic                        i_ready,
  output logic [fp2_pkg::FE_BITS-1:0]  o_re,
  output logic [fp2_pkg::FE_BITS-1:0]  o_im,
  output logic [fp2_pkg::TAG_BITS-1:0] o_tag,
  // Fp adder / subtractor
  output logic                        o_as_valid,
  input  logic                        i_as_ready,
  output logic                        o_as_sub,
  output logic [fp2_pkg::FE_BITS-1:0]  o_as_x,
  output logic [fp2_pkg::FE_BITS-1:0]  o_as_y,
  input  logic                        i_as_res_valid,
  output logic                        o_as_res_ready,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_as_z,
  // Fp multiplier
  output logic                        o_mul_valid,
  input  logic                        i_mul_ready,
  output logic [fp2_pkg::FE_BITS-1:0]  o_mul_x,
  output logic [fp2_pkg::FE_BITS-1:0]  o_mul_y,
  input  logic                        i_mul_res_valid,
  output logic                        o_mul_res_ready,
  input  logic [fp2_pkg::FE_BITS-1:0]  i_mul_z
);
  import fp2_pkg::*;

  seq_state_e         state;
  fp2_op_e            op_q;
  logic               fp_q;
  logic               issued;
  logic               use_as;
  logic               use_mul;
  logic               res_got;
  logic [FE_BITS-1:0] fe_z;
  logic [FE_BITS-1:0] a_re_q, a_im_q, b_re_q, b_im_q;
  // Products paired for the real and imaginary combine steps
  logic [FE_BITS-1:0] p_rr, p_ii, p_ri, p_ir;

  assign o_ready         = (state == S_IDLE);
  assign o_valid         = (state == S_DONE);
  assign o_as_valid      = use_as & ~issued;
  assign o_as_res_ready  = use_as & issued;
  assign o_mul_valid     = use_mul & ~issued;
  assign o_mul_res_ready = use_mul & issued;
  assign res_got = (o_as_res_ready & i_as_res_valid) | (o_mul_res_ready & i_mul_res_valid);
  assign fe_z    = use_as ? i_as_z : i_mul_z;

  // Operand select for the unit owned by the current state
  always_comb begin
    use_as   = 1'b0;
    use_mul  = 1'b0;
    o_as_sub = 1'b0;
    o_as_x   = '0;
    o_as_y   = '0;
    o_mul_x  = '0;
    o_mul_y  = '0;
    case (state)
      S_AS_RE:   begin use_as = 1'b1;  o_as_sub = (op_q == OP_SUB);
                   o_as_x = a_re_q;  o_as_y = b_re_q; end
      S_AS_IM:   begin use_as = 1'b1;  o_as_sub = (op_q == OP_SUB);
                   o_as_x = a_im_q;  o_as_y = b_im_q; end
      S_MUL0:    begin use_mul = 1'b1; o_mul_x = a_re_q; o_mul_y = b_re_q; end
      S_MUL1:    begin use_mul = 1'b1; o_mul_x = a_im_q; o_mul_y = b_im_q; end
      S_MUL2:    begin use_mul = 1'b1; o_mul_x = a_re_q; o_mul_y = b_im_q; end
      S_MUL3:    begin use_mul = 1'b1; o_mul_x = a_im_q; o_mul_y = b_re_q; end
      S_COMB_RE: begin use_as = 1'b1;  o_as_sub = 1'b1; o_as_x = p_rr; o_as_y = p_ii; end
      S_COMB_IM: begin use_as = 1'b1;  o_as_x = p_ri; o_as_y = p_ir; end
      default:   ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      issued <= 1'b0;
    end else begin
      if ((o_as_valid && i_as_ready) || (o_mul_valid && i_mul_ready)) issued <= 1'b1;
      if (res_got) issued <= 1'b0;
      case (state)
        S_IDLE: if (i_valid) begin
          op_q   <= i_op;
          fp_q   <= i_fp_mode;
          a_re_q <= i_a_re;
          a_im_q <= i_a_im;
          b_re_q <= i_b_re;
          b_im_q <= i_b_im;
          o_tag  <= i_tag;
          // Stays zero in fp mode
          o_im   <= '0;
          state  <= (i_op == OP_MUL) ? S_MUL0 : S_AS_RE;
        end
        S_AS_RE: if (res_got) begin
          o_re  <= fe_z;
          state <= fp_q ? S_DONE : S_AS_IM;
        end
        S_AS_IM: if (res_got) begin
          o_im  <= fe_z;
          state <= S_DONE;
        end
        S_MUL0: if (res_got) begin
          p_rr  <= fe_z;
          o_re  <= fe_z;
          state <= fp_q ? S_DONE : S_MUL1;
        end
        S_MUL1: if (res_got) begin
          p_ii  <= fe_z;
          state <= S_MUL2;
        end
        S_MUL2: if (res_got) begin
          p_ri  <= fe_z;
          state <= S_MUL3;
        end
        S_MUL3: if (res_got) begin
          p_ir  <= fe_z;
          state <= S_COMB_RE;
        end
        S_COMB_RE: if (res_got) begin
          o_re  <= fe_z;
          state <= S_COMB_IM;
        end
        S_COMB_IM: if (res_got) begin
          o_im  <= fe_z;
          state <= S_DONE;
        end
        S_DONE: if (i_ready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- fp_add_sub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fp modular adder / subtractor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fp_add_sub (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_valid,
  input  logic                       i_sub,
  input  logic [fp2_pkg::FE_BITS-1:0] i_x,
  input  logic [fp2_pkg::FE_BITS-1:0] i_y,
  output logic                       o_ready,
  output logic                       o_valid,
  output logic [fp2_pkg::FE_BITS-1:0] o_z,
  input  logic                       i_ready
);
  import fp2_pkg::*;

  logic [FE_BITS:0]   sum;
  logic [FE_BITS-1:0] z_next;

  // New request may enter while the current result drains
  assign o_ready = ~o_valid | i_ready;

  always_comb begin
    sum = {1'b0, i_x} + {1'b0, i_y};
    if (i_sub) begin
      // Borrow case wraps back into the field
      z_next = (i_x >= i_y) ? i_x - i_y : i_x + (FE_P - i_y);
    end else begin
      z_next = (sum >= {1'b0, FE_P}) ? FE_BITS'(sum - {1'b0, FE_P}) : sum[FE_BITS-1:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_z <= z_next;
    end
  end

endmodule

//--- fp_mul_iter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit-serial Fp multiplier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fp_mul_iter (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_valid,
  input  logic [fp2_pkg::FE_BITS-1:0] i_x,
  input  logic [fp2_pkg::FE_BITS-1:0] i_y,
  output logic                       o_ready,
  output logic                       o_valid,
  output logic [fp2_pkg::FE_BITS-1:0] o_z,
  input  logic                       i_ready
);
  import fp2_pkg::*;

  logic                 busy;
  logic                 accept;
  logic                 step;
  logic                 cnt_done;
  logic [STEP_BITS-1:0] bit_idx;
  logic [FE_BITS-1:0]   x_q;
  logic [FE_BITS-1:0]   y_q;
  logic [FE_BITS-1:0]   acc;
  logic [FE_BITS-1:0]   acc_dbl;
  logic [FE_BITS-1:0]   acc_next;

  // Sum of two reduced values needs at most one correction
  function automatic logic [FE_BITS-1:0] mod_add(input logic [FE_BITS-1:0] a,
                                                 input logic [FE_BITS-1:0] b);
    logic [FE_BITS:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, FE_P}) begin
      s = s - {1'b0, FE_P};
    end
    return s[FE_BITS-1:0];
  endfunction

  assign o_ready  = ~busy & ~o_valid;
  assign accept   = i_valid & o_ready;
  assign step     = busy & ~cnt_done;
  assign acc_dbl  = mod_add(acc, acc);
  assign acc_next = y_q[bit_idx[$clog2(FE_BITS)-1:0]] ? mod_add(acc_dbl, x_q) : acc_dbl;
  assign o_z      = acc;

  mul_step_counter mul_step_counter_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_load  (accept),
    .i_step  (step),
    .o_index (bit_idx),
    .o_done  (cnt_done)
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy    <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      if (o_valid && i_ready) o_valid <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
      end else if (cnt_done) begin
        // Accumulator now holds the product
        busy    <= 1'b0;
        o_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      x_q <= i_x;
      y_q <= i_y;
      acc <= '0;
    end else if (step) begin
      acc <= acc_next;
    end
  end

endmodule

//--- mul_step_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiplier bit-step counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mul_step_counter (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_load,
  input  logic                         i_step,
  output logic [fp2_pkg::STEP_BITS-1:0] o_index,
  output logic                         o_done
);
  import fp2_pkg::*;

  logic [STEP_BITS-1:0] count;

  // Bit under work, MSB first
  assign o_index = count - STEP_BITS'(1);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count  <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_load) begin
        count <= STEP_BITS'(FE_BITS);
      end else if (i_step && count != '0) begin
        count  <= count - STEP_BITS'(1);
        // Pulse together with the last decrement
        o_done <= (count == STEP_BITS'(1));
      end
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Fp2 ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fp2_alu -f tb.f -Mdir obj_dir; then
  echo "Build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_fp2_alu)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF '*** PASSED ***' <<< "$sim_out"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

//--- tb.f
fp2_pkg.sv
fp_add_sub.sv
mul_step_counter.sv
fp_mul_iter.sv
fp2_sequencer.sv
fp2_alu_top.sv
fp2_alu_props.sv
tb_fp2_alu.sv

//--- tb_fp2_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fp2 ALU random testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_fp2_alu;
  import fp2_pkg::*;

  localparam int NUM_OPS    = 300;
  localparam int MAX_CYCLES = NUM_OPS * 100;
  localparam int P          = int'(FE_P);

  logic                i_clk;
  logic                i_rst;
  logic                i_valid;
  logic                o_ready;
  fp2_op_e             i_op;
  logic                i_fp_mode;
  logic [FE_BITS-1:0]  i_a_re, i_a_im, i_b_re, i_b_im;
  logic [TAG_BITS-1:0] i_tag;
  logic                o_valid;
  logic                i_ready;
  logic [FE_BITS-1:0]  o_re, o_im;
  logic [TAG_BITS-1:0] o_tag;

  // Expected results in acceptance order
  int exp_re[$];
  int exp_im[$];
  int exp_tag[$];
  int accepted;
  int checked;

  fp2_alu_top fp2_alu_top_inst (
    .i_clk (i_clk), .i_rst (i_rst), .i_valid (i_valid), .o_ready (o_ready),
    .i_op (i_op), .i_fp_mode (i_fp_mode),
    .i_a_re (i_a_re), .i_a_im (i_a_im), .i_b_re (i_b_re), .i_b_im (i_b_im),
    .i_tag (i_tag), .o_valid (o_valid), .i_ready (i_ready),
    .o_re (o_re), .o_im (o_im), .o_tag (o_tag)
  );

  function automatic int field_add(int a, int b);
    return (a + b) % P;
  endfunction

  function automatic int field_sub(int a, int b);
    return (a - b + P) % P;
  endfunction

  function automatic int field_mul(int a, int b);
    longint prod;
    prod = longint'(a) * longint'(b);
    return int'(prod % longint'(P));
  endfunction

  // Edge values 0, 1 and P-1 show up often
  function automatic logic [FE_BITS-1:0] random_element();
    int sel;
    sel = $urandom_range(0, 9);
    case (sel)
      0:       return '0;
      1:       return FE_BITS'(1);
      2:       return FE_P - FE_BITS'(1);
      default: return FE_BITS'($urandom_range(0, P - 1));
    endcase
  endfunction

  task automatic check_value(string name, int got, int expected);
    if (got != expected) begin
      $display("** Error at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
      $display("*** FAILED ***");
      $fatal(1, "Result mismatch");
    end
  endtask

  task automatic push_expected();
    int ar, ai, br, bi, re, im;
    ar = int'(i_a_re);
    ai = int'(i_a_im);
    br = int'(i_b_re);
    bi = int'(i_b_im);
    case (i_op)
      OP_ADD: begin
        re = field_add(ar, br);
        im = field_add(ai, bi);
      end
      OP_SUB: begin
        re = field_sub(ar, br);
        im = field_sub(ai, bi);
      end
      default: begin
        re = i_fp_mode ? field_mul(ar, br) : field_sub(field_mul(ar, br), field_mul(ai, bi));
        im = field_add(field_mul(ar, bi), field_mul(ai, br));
      end
    endcase
    // Plain Fp path has no imaginary part
    if (i_fp_mode) im = 0;
    exp_re.push_back(re);
    exp_im.push_back(im);
    exp_tag.push_back(int'(i_tag));
  endtask

  task automatic drive_operation();
    i_valid   <= 1'b1;
    i_op      <= fp2_op_e'(2'($urandom_range(0, 2)));
    i_fp_mode <= ($urandom_range(0, 3) == 0);
    i_a_re    <= random_element();
    i_a_im    <= random_element();
    i_b_re    <= random_element();
    i_b_im    <= random_element();
    i_tag     <= TAG_BITS'($urandom);
  endtask

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial begin : stimulus
    int   seed_ret;
    logic taken;
    seed_ret  = $urandom(32'h2be8561c);
    i_rst     = 1'b1;
    i_valid   = 1'b0;
    i_op      = OP_ADD;
    i_fp_mode = 1'b0;
    i_a_re    = '0;
    i_a_im    = '0;
    i_b_re    = '0;
    i_b_im    = '0;
    i_tag     = '0;
    i_ready   = 1'b0;
    accepted  = 0;
    checked   = 0;
    repeat (4) @(posedge i_clk);
    i_rst <= 1'b0;
    while (accepted < NUM_OPS) begin
      // Handshake is settled between the edges
      @(negedge i_clk);
      taken = i_valid && o_ready;
      if (taken) begin
        push_expected();
        accepted++;
      end
      @(posedge i_clk);
      i_ready <= ($urandom_range(0, 3) != 0);
      // A pending request holds until it is taken
      if (taken || !i_valid) begin
        if (accepted < NUM_OPS && $urandom_range(0, 2) != 0) drive_operation();
        else i_valid <= 1'b0;
      end
    end
    while (checked < NUM_OPS) begin
      @(posedge i_clk);
      i_ready <= ($urandom_range(0, 3) != 0);
    end
    i_ready <= 1'b1;
    // Idle cycles catch any extra result
    repeat (20) @(posedge i_clk);
    if (checked == NUM_OPS && exp_re.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Checked %0d results, %0d still expected", checked, exp_re.size());
      $display("*** FAILED ***");
      $fatal(1, "Result count mismatch");
    end
  end

  initial begin : monitor
    forever begin
      @(negedge i_clk);
      if (!i_rst && o_valid && i_ready) begin
        if (exp_re.size() == 0) begin
          $display("A result came out with no operation outstanding at %0t ns", $time);
          $display("*** FAILED ***");
          $fatal(1, "Unexpected result");
        end else begin
          check_value("o_re", int'(o_re), exp_re.pop_front());
          check_value("o_im", int'(o_im), exp_im.pop_front());
          check_value("o_tag", int'(o_tag), exp_tag.pop_front());
          checked++;
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge i_clk);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("The run timed out after %0d cycles with %0d results checked", cycles, checked);
        $display("*** FAILED ***");
        $fatal(1, "Timeout");
      end
    end
  end

endmodule
